// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module tb_dcache -f tb.f -o tb_dcache
	./obj_dir/tb_dcache | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dcache_ctrl.sv
// data cache request controller
`timescale 1ns/1ns

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,

    input  logic              req_valid_i,
    input  logic              req_write_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [WORD_W-1:0] req_wdata_i,
    input  logic [STRB_W-1:0] req_strb_i,
    output logic              resp_done_o,
    output logic [WORD_W-1:0] resp_rdata_o,

    output logic              mem_req_o,
    output mem_cmd_e          mem_cmd_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic [WORD_W-1:0] mem_wdata_o,
    input  logic              mem_ack_i,
    input  logic [WORD_W-1:0] mem_rdata_i,

    way_if.ctrl               way0,
    way_if.ctrl               way1
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_index;

    logic [1:0] hit_vec;
    logic       hit;
    logic [1:0] wr_hit_vec;
    logic [1:0] refill_wr;
    logic [1:0] wb_done;

    logic [NUM_SETS-1:0] lru_bits;
    logic                miss_victim;
    logic                victim_dirty;
    logic                victim_q;

    logic [TAG_W-1:0]  victim_tag;
    logic [WORD_W-1:0] victim_data;
    logic [WORD_W-1:0] fill_data;

    assign req_tag   = req_addr_i[ADDR_W-1 -: TAG_W];
    assign req_index = req_addr_i[OFFSET_W +: INDEX_W];

    // tag compare on the registered way outputs
    assign hit_vec[0] = way0.valid_out && (way0.tag_out == req_tag);
    assign hit_vec[1] = way1.valid_out && (way1.tag_out == req_tag);
    assign hit        = |hit_vec;

    // invalid way first, then the least recently used one
    always_comb begin
        if (!way0.valid_out) begin
            miss_victim = 1'b0;
        end else if (!way1.valid_out) begin
            miss_victim = 1'b1;
        end else begin
            miss_victim = lru_bits[req_index];
        end
    end

    assign victim_dirty = miss_victim ? (way1.valid_out && way1.dirty_out)
                                      : (way0.valid_out && way0.dirty_out);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_valid_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    state_d = ST_IDLE;
                end else if (victim_dirty) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                if (mem_ack_i) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (mem_ack_i) begin
                    state_d = ST_RELOAD;
                end
            end
            // arrays hold the new line one read later
            ST_RELOAD: begin
                state_d = ST_LOOKUP;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // victim held for the whole miss
    always_ff @(posedge clk) begin
        if (reset_i) begin
            victim_q <= 1'b0;
        end else if (state_q == ST_LOOKUP && !hit) begin
            victim_q <= miss_victim;
        end
    end

    // lru bit names the way not touched by the last hit
    always_ff @(posedge clk) begin
        if (reset_i) begin
            lru_bits <= '0;
        end else if (state_q == ST_LOOKUP && hit) begin
            lru_bits[req_index] <= hit_vec[0];
        end
    end

    assign resp_done_o  = (state_q == ST_LOOKUP) && hit;
    assign resp_rdata_o = hit_vec[1] ? way1.data_out : way0.data_out;

    // memory side
    assign victim_tag  = victim_q ? way1.tag_out  : way0.tag_out;
    assign victim_data = victim_q ? way1.data_out : way0.data_out;

    assign mem_req_o   = (state_q == ST_WRITEBACK) || (state_q == ST_REFILL);
    assign mem_cmd_o   = (state_q == ST_WRITEBACK) ? CMD_WRITEBACK : CMD_REFILL;
    assign mem_addr_o  = (state_q == ST_WRITEBACK)
                       ? {victim_tag, req_index, {OFFSET_W{1'b0}}}
                       : {req_tag, req_index, {OFFSET_W{1'b0}}};
    assign mem_wdata_o = victim_data;

    // per-way write controls
    assign wr_hit_vec = (state_q == ST_LOOKUP && req_write_i) ? hit_vec : 2'b00;
    assign refill_wr  = (state_q == ST_REFILL && mem_ack_i)
                      ? {victim_q, !victim_q} : 2'b00;
    assign wb_done    = (state_q == ST_WRITEBACK && mem_ack_i)
                      ? {victim_q, !victim_q} : 2'b00;
    assign fill_data  = (state_q == ST_REFILL) ? mem_rdata_i : req_wdata_i;

    assign way0.index     = req_index;
    assign way0.tag_wr    = refill_wr[0];
    assign way0.tag_in    = req_tag;
    assign way0.data_be   = refill_wr[0] ? {STRB_W{1'b1}}
                          : (wr_hit_vec[0] ? req_strb_i : '0);
    assign way0.data_in   = fill_data;
    assign way0.dirty_set = wr_hit_vec[0];
    assign way0.dirty_clr = wb_done[0];

    assign way1.index     = req_index;
    assign way1.tag_wr    = refill_wr[1];
    assign way1.tag_in    = req_tag;
    assign way1.data_be   = refill_wr[1] ? {STRB_W{1'b1}}
                          : (wr_hit_vec[1] ? req_strb_i : '0);
    assign way1.data_in   = fill_data;
    assign way1.dirty_set = wr_hit_vec[1];
    assign way1.dirty_clr = wb_done[1];

endmodule

// File: dcache_pkg.sv
// data cache shared definitions
package dcache_pkg;

    // address and data sizes
    localparam int ADDR_W = 64;
    localparam int WORD_W = 64;
    localparam int STRB_W = 8;

    // address split into tag, index and byte offset
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = 55;

    // one word per set
    localparam int NUM_SETS = 64;

    // request controller states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LOOKUP    = 3'd1,
        ST_WRITEBACK = 3'd2,
        ST_REFILL    = 3'd3,
        ST_RELOAD    = 3'd4
    } ctrl_state_e;

    // memory-side command, held with mem_req_o
    typedef enum logic {
        CMD_WRITEBACK = 1'b0,
        CMD_REFILL    = 1'b1
    } mem_cmd_e;

endpackage

// File: dcache_top.sv
// two-way data cache
`timescale 1ns/1ns

module dcache_top
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,

    // core side
    input  logic              req_valid_i,
    input  logic              req_write_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [WORD_W-1:0] req_wdata_i,
    input  logic [STRB_W-1:0] req_strb_i,
    output logic              resp_done_o,
    output logic [WORD_W-1:0] resp_rdata_o,

    // memory side
    output logic              mem_req_o,
    output mem_cmd_e          mem_cmd_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic [WORD_W-1:0] mem_wdata_o,
    input  logic              mem_ack_i,
    input  logic [WORD_W-1:0] mem_rdata_i
);

    way_if way0_bus ();
    way_if way1_bus ();

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_strb_i   (req_strb_i),
        .resp_done_o  (resp_done_o),
        .resp_rdata_o (resp_rdata_o),
        .mem_req_o    (mem_req_o),
        .mem_cmd_o    (mem_cmd_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i),
        .way0         (way0_bus.ctrl),
        .way1         (way1_bus.ctrl)
    );

    dcache_way u_way0 (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (way0_bus.way)
    );

    dcache_way u_way1 (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (way1_bus.way)
    );

endmodule

// File: dcache_way.sv
// cache way storage
`timescale 1ns/1ns

module dcache_way
    import dcache_pkg::*;
(
    input  logic clk,
    input  logic reset_i,
    way_if.way   bus
);

    logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
    logic [WORD_W-1:0]   data_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid_bits;
    logic [NUM_SETS-1:0] dirty_bits;

    // byte-masked data write
    always_ff @(posedge clk) begin
        for (int b = 0; b < STRB_W; b++) begin
            if (bus.data_be[b]) begin
                data_mem[bus.index][b*8 +: 8] <= bus.data_in[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.tag_wr) begin
            tag_mem[bus.index] <= bus.tag_in;
        end
    end

    // a new tag makes the line valid and clean
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_bits <= '0;
        end else if (bus.tag_wr) begin
            valid_bits[bus.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dirty_bits <= '0;
        end else if (bus.tag_wr) begin
            dirty_bits[bus.index] <= 1'b0;
        end else if (bus.dirty_set) begin
            dirty_bits[bus.index] <= 1'b1;
        end else if (bus.dirty_clr) begin
            dirty_bits[bus.index] <= 1'b0;
        end
    end

    // synchronous read, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        bus.valid_out <= valid_bits[bus.index];
        bus.dirty_out <= dirty_bits[bus.index];
        bus.tag_out   <= tag_mem[bus.index];
        bus.data_out  <= data_mem[bus.index];
    end

endmodule

// File: tb.f
dcache_pkg.sv
way_if.sv
dcache_way.sv
dcache_ctrl.sv
dcache_top.sv
tb_clock.sv
tb_dcache_asserts.sv
tb_dcache.sv

// File: tb_clock.sv
// testbench clock source
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

// File: tb_dcache.sv
// data cache testbench
`timescale 1ns/1ns

module tb_dcache
    import dcache_pkg::*;
();

    localparam logic [63:0] INIT_MASK  = 64'hC0DE_0000_0000_0000;
    localparam int          TIMEOUT    = 100;
    localparam int          NUM_ROWS   = 13;
    localparam int          NUM_RANDOM = 40;

    typedef struct packed {
        logic        write;
        logic [63:0] addr;
        logic [63:0] wdata;
        logic [7:0]  strb;
        logic [63:0] rdata;
        logic        exp_wb;
        logic        exp_fill;
        logic [63:0] wb_addr;
    } table_row_t;

    logic              clk;
    logic              reset_i;
    logic              req_valid_i;
    logic              req_write_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic [WORD_W-1:0] req_wdata_i;
    logic [STRB_W-1:0] req_strb_i;
    logic              resp_done_o;
    logic [WORD_W-1:0] resp_rdata_o;
    logic              mem_req_o;
    mem_cmd_e          mem_cmd_o;
    logic [ADDR_W-1:0] mem_addr_o;
    logic [WORD_W-1:0] mem_wdata_o;
    logic              mem_ack_i;
    logic [WORD_W-1:0] mem_rdata_i;

    table_row_t  rows [NUM_ROWS];
    logic [63:0] ref_mem [logic [63:0]];
    logic [63:0] shadow_mem [logic [63:0]];
    logic [63:0] wb_log [$];
    logic [63:0] fill_log [$];
    mem_cmd_e    cmd_log [$];
    logic [15:0] stim_lfsr;

    tb_clock u_clock (.clk(clk));

    dcache_top dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_strb_i   (req_strb_i),
        .resp_done_o  (resp_done_o),
        .resp_rdata_o (resp_rdata_o),
        .mem_req_o    (mem_req_o),
        .mem_cmd_o    (mem_cmd_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    bind dcache_ctrl tb_dcache_asserts u_asserts (
        .clk         (clk),
        .reset_i     (reset_i),
        .state_i     (state_q),
        .mem_req_i   (mem_req_o),
        .mem_cmd_i   (mem_cmd_o),
        .mem_addr_i  (mem_addr_o),
        .mem_wdata_i (mem_wdata_o),
        .mem_ack_i   (mem_ack_i),
        .resp_done_i (resp_done_o)
    );

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t ns: %s got %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic [63:0] take_bits(input int n, inout logic [15:0] state);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v     = {v[62:0], state[0]};
            state = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
        end
        return v;
    endfunction

    function automatic logic [63:0] align_addr(input logic [63:0] addr);
        return {addr[63:3], 3'b000};
    endfunction

    // unwritten memory reads as its word address with a fixed mask
    function automatic logic [63:0] initial_word(input logic [63:0] addr);
        return align_addr(addr) ^ INIT_MASK;
    endfunction

    function automatic logic [63:0] ref_read(input logic [63:0] addr);
        logic [63:0] a;
        a = align_addr(addr);
        return ref_mem.exists(a) ? ref_mem[a] : initial_word(a);
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] wdata,
                                                input logic [7:0]  strb);
        logic [63:0] mask;
        for (int b = 0; b < 8; b++) begin
            mask[b*8 +: 8] = {8{strb[b]}};
        end
        return (old_word & ~mask) | (wdata & mask);
    endfunction

    // two indexes and four tags
    function automatic logic [63:0] make_addr(input logic [1:0] tag, input logic sel,
                                              input logic [2:0] off);
        return {53'd0, tag, (sel ? 6'd9 : 6'd5), off};
    endfunction

    function automatic void load_table();
        // cold read, partial write and read hit at index 0
        rows[0]  = '{1'b0, 64'h1000, 64'h0, 8'h00, 64'hC0DE_0000_0000_1000, 1'b0, 1'b1, 64'h0};
        rows[1]  = '{1'b1, 64'h1000, 64'h1111_2222_3333_4444, 8'h0F, 64'h0, 1'b0, 1'b0, 64'h0};
        rows[2]  = '{1'b0, 64'h1000, 64'h0, 8'h00, 64'hC0DE_0000_3333_4444, 1'b0, 1'b0, 64'h0};
        // third write to index 5 evicts a dirty line
        rows[3]  = '{1'b1, 64'h0028, 64'hAAAA_AAAA_AAAA_AAAA, 8'hFF, 64'h0, 1'b0, 1'b1, 64'h0};
        rows[4]  = '{1'b1, 64'h0228, 64'hBBBB_BBBB_BBBB_BBBB, 8'hF0, 64'h0, 1'b0, 1'b1, 64'h0};
        rows[5]  = '{1'b1, 64'h0428, 64'hCCCC_CCCC_CCCC_CCCC, 8'h01, 64'h0, 1'b1, 1'b1, 64'h28};
        // clean evictions at index 7
        rows[6]  = '{1'b0, 64'h0038, 64'h0, 8'h00, 64'hC0DE_0000_0000_0038, 1'b0, 1'b1, 64'h0};
        rows[7]  = '{1'b0, 64'h0238, 64'h0, 8'h00, 64'hC0DE_0000_0000_0238, 1'b0, 1'b1, 64'h0};
        rows[8]  = '{1'b0, 64'h0438, 64'h0, 8'h00, 64'hC0DE_0000_0000_0438, 1'b0, 1'b1, 64'h0};
        rows[9]  = '{1'b0, 64'h0038, 64'h0, 8'h00, 64'hC0DE_0000_0000_0038, 1'b0, 1'b1, 64'h0};
        // written-back lines come back from memory
        rows[10] = '{1'b0, 64'h0028, 64'h0, 8'h00, 64'hAAAA_AAAA_AAAA_AAAA, 1'b1, 1'b1, 64'h228};
        rows[11] = '{1'b0, 64'h0428, 64'h0, 8'h00, 64'hC0DE_0000_0000_04CC, 1'b0, 1'b0, 64'h0};
        rows[12] = '{1'b0, 64'h0228, 64'h0, 8'h00, 64'hBBBB_BBBB_0000_0228, 1'b0, 1'b1, 64'h0};
    endfunction

    // request held until resp_done_o and dropped one cycle later
    task automatic run_access(input logic wr, input logic [63:0] addr,
                              input logic [63:0] wdata, input logic [7:0] strb,
                              output logic [63:0] rdata, output int cycles);
        wb_log.delete();
        fill_log.delete();
        cmd_log.delete();
        if (wr) begin
            ref_mem[align_addr(addr)] = merge_bytes(ref_read(addr), wdata, strb);
        end
        req_valid_i = 1'b1;
        req_write_i = wr;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        req_strb_i  = strb;
        cycles      = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                stop_on_error("no resp_done_o pulse before the timeout");
            end
        end while (!resp_done_o);
        rdata = resp_rdata_o;
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_strb_i  = '0;
    endtask

    task automatic read_expect(input logic [63:0] addr);
        logic [63:0] rdata;
        int          cycles;
        run_access(1'b0, addr, 64'h0, 8'h00, rdata, cycles);
        check_value("resp_rdata_o", rdata, ref_read(addr));
    endtask

    task automatic apply_row(input table_row_t row);
        logic [63:0] rdata;
        int          cycles;
        run_access(row.write, row.addr, row.wdata, row.strb, rdata, cycles);
        if (!row.write) begin
            check_value("resp_rdata_o", rdata, row.rdata);
        end
        check_value("writeback count", 64'(wb_log.size()), 64'(row.exp_wb));
        check_value("refill count", 64'(fill_log.size()), 64'(row.exp_fill));
        if (row.exp_wb) begin
            check_value("mem_addr_o (writeback)", wb_log[0], row.wb_addr);
            check_value("mem_cmd_o (first)", 64'(cmd_log[0]), 64'(CMD_WRITEBACK));
        end
        if (row.exp_fill) begin
            check_value("mem_addr_o (refill)", fill_log[0], align_addr(row.addr));
        end else begin
            check_value("hit latency", 64'(cycles), 64'd1);
        end
    endtask

    task automatic random_access();
        logic [63:0] bits;
        logic [63:0] wdata;
        logic [63:0] addr;
        logic [63:0] rdata;
        int          cycles;
        bits  = take_bits(15, stim_lfsr);
        wdata = take_bits(64, stim_lfsr);
        addr  = make_addr(bits[13:12], bits[11], bits[10:8]);
        if (bits[14]) begin
            run_access(1'b1, addr, wdata, bits[7:0], rdata, cycles);
        end else begin
            read_expect(addr);
        end
    endtask

    task automatic serve_request();
        logic [63:0] addr;
        addr = mem_addr_o;
        check_value("mem_addr_o offset", 64'(addr[2:0]), 64'd0);
        mem_ack_i = 1'b1;
        if (mem_cmd_o == CMD_WRITEBACK) begin
            // a dirty line always holds the latest written value
            check_value("mem_wdata_o", mem_wdata_o, ref_read(addr));
            shadow_mem[addr] = mem_wdata_o;
            wb_log.push_back(addr);
        end else begin
            mem_rdata_i = shadow_mem.exists(addr) ? shadow_mem[addr] : initial_word(addr);
            fill_log.push_back(addr);
        end
        cmd_log.push_back(mem_cmd_o);
    endtask

    // memory model with 0 to 3 idle cycles before each acknowledge
    initial begin : memory_model
        logic [15:0] mem_lfsr;
        logic        busy;
        int          gap;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        mem_lfsr    = 16'd80;
        busy        = 1'b0;
        gap         = 0;
        forever begin
            @(posedge clk);
            #1;
            mem_ack_i = 1'b0;
            if (mem_req_o) begin
                if (!busy) begin
                    busy = 1'b1;
                    gap  = int'(take_bits(2, mem_lfsr));
                end
                if (gap == 0) begin
                    serve_request();
                    busy = 1'b0;
                end else begin
                    gap--;
                end
            end
        end
    end

    initial begin
        reset_i     = 1'b1;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        req_strb_i  = '0;
        stim_lfsr   = 16'd80;
        load_table();
        repeat (16) @(posedge clk);
        #1;
        reset_i = 1'b0;
        repeat (8) begin
            @(posedge clk);
            #1;
            check_value("resp_done_o", 64'(resp_done_o), 64'd0);
            check_value("mem_req_o", 64'(mem_req_o), 64'd0);
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(rows[i]);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_access();
        end
        // second pass forces every line back in through a miss
        for (int pass = 0; pass < 2; pass++) begin
            for (int t = 0; t < 4; t++) begin
                read_expect(make_addr(2'(t), 1'b0, 3'd0));
                read_expect(make_addr(2'(t), 1'b1, 3'd0));
            end
        end
        if (dut.u_ctrl.u_asserts.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_on_error("a handshake assertion failed during the run");
        end
    end

endmodule

// File: tb_dcache_asserts.sv
// cache controller handshake assertions
`timescale 1ns/1ns

module tb_dcache_asserts
    import dcache_pkg::*;
(
    input logic              clk,
    input logic              reset_i,
    input ctrl_state_e       state_i,
    input logic              mem_req_i,
    input mem_cmd_e          mem_cmd_i,
    input logic [ADDR_W-1:0] mem_addr_i,
    input logic [WORD_W-1:0] mem_wdata_i,
    input logic              mem_ack_i,
    input logic              resp_done_i
);

    int fail_count;

    initial begin
        fail_count = 0;
    end

    // request and its fields held until the acknowledge
    assert property (@(posedge clk) disable iff (reset_i)
        mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_cmd_i)
            && $stable(mem_addr_i) && $stable(mem_wdata_i))
    else begin
        fail_count++;
        $error("memory request dropped or changed before mem_ack_i");
    end

    assert property (@(posedge clk) disable iff (reset_i)
        resp_done_i |=> !resp_done_i)
    else begin
        fail_count++;
        $error("resp_done_o high for two cycles");
    end

    assert property (@(posedge clk) disable iff (reset_i)
        state_i == ST_IDLE |-> !mem_req_i)
    else begin
        fail_count++;
        $error("mem_req_o high in the idle state");
    end

endmodule

// File: way_if.sv
// cache way access interface
`timescale 1ns/1ns

interface way_if
    import dcache_pkg::*;
();

    // driven by the controller
    logic [INDEX_W-1:0] index;
    logic               tag_wr;
    logic [TAG_W-1:0]   tag_in;
    logic [STRB_W-1:0]  data_be;
    logic [WORD_W-1:0]  data_in;
    logic               dirty_set;
    logic               dirty_clr;

    // registered read of the previous cycle's index
    logic               valid_out;
    logic               dirty_out;
    logic [TAG_W-1:0]   tag_out;
    logic [WORD_W-1:0]  data_out;

    modport ctrl (
        output index, tag_wr, tag_in, data_be, data_in, dirty_set, dirty_clr,
        input  valid_out, dirty_out, tag_out, data_out
    );

    modport way (
        input  index, tag_wr, tag_in, data_be, data_in, dirty_set, dirty_clr,
        output valid_out, dirty_out, tag_out, data_out
    );

endinterface
